// File: com_link.f
common/com_pkg.sv
logic/com_cmd_decode.sv
com_txf/com_txf.sv
com_rxf/com_rxf.sv
logic/com_link.sv
tests/com_link_checker.sv
tests/tb_com_link.sv

// File: com_rxf/com_rxf.sv
`timescale 1ns/1ps

module com_rxf #(
    parameter int GUARD_BITS = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                line_en,
    input  logic                line_data,
    output logic                rx_byte_valid,
    output logic [7:0]          rx_byte,
    output logic                frame_valid,
    output com_pkg::rx_status_t frame_status
);
    import com_pkg::*;

    // enough for sync, 255 payload bytes and the guard
    localparam int CNT_W     = $clog2(8 * 256 + GUARD_BITS + 1);
    localparam int TAIL_BITS = 8 + GUARD_BITS;  // line bits that carry no payload

    rx_state_t        state;
    logic [CNT_W-1:0] bit_cnt;  // line bits seen in this frame
    logic [CNT_W-1:0] payload_bits;
    logic [7:0]       shreg;
    logic [7:0]       next_byte;
    logic             sync_ok;
    logic             byte_done;
    logic             frame_end;

    assign next_byte = {shreg[6:0], line_data};
    assign byte_done = line_en && (bit_cnt[2:0] == 3'd7);
    assign frame_end = !line_en && (bit_cnt != '0) && (state != END);

    // guard length is known, so the tail is taken off the bit count
    assign payload_bits = (bit_cnt >= CNT_W'(TAIL_BITS)) ? bit_cnt - CNT_W'(TAIL_BITS) : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= HUNT;
            bit_cnt       <= '0;
            sync_ok       <= 1'b0;
            rx_byte_valid <= 1'b0;
            frame_valid   <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0;
            frame_valid   <= frame_end;
            if (line_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            case (state)
                HUNT: begin
                    if (byte_done) begin
                        sync_ok <= (next_byte == SYNC_BYTE);
                        state   <= BYTES;
                    end else if (frame_end) begin
                        state <= END;  // frame shorter than the sync byte
                    end
                end
                BYTES: begin
                    // guard bytes get strobed too, end of frame is not known yet
                    if (byte_done) begin
                        rx_byte_valid <= sync_ok;
                    end else if (frame_end) begin
                        state <= END;
                    end
                end
                END: begin
                    bit_cnt <= '0;
                    sync_ok <= 1'b0;
                    state   <= HUNT;
                end
                default: begin
                    state <= HUNT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (line_en) begin
            shreg <= next_byte;
        end
        if (byte_done) begin
            rx_byte <= next_byte;
        end
        if (frame_end) begin
            frame_status.sync_ok    <= sync_ok;
            frame_status.byte_count <= sync_ok ? payload_bits[10:3] : 8'd0;
            frame_status.short_byte <= |payload_bits[2:0];
        end
    end

    // status only goes out once the transmitter has released the line
    a_status_after_frame: assert property (@(posedge clk) disable iff (rst)
        frame_valid |-> !line_en);

endmodule

// File: com_txf/com_txf.sv
`timescale 1ns/1ps

module com_txf #(
    parameter int GUARD_BITS = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    input  logic       tx_last,
    output logic       byte_next,
    output logic       tx_done,
    output logic       line_en,
    output logic       line_data
);
    import com_pkg::*;

    localparam int GW = (GUARD_BITS > 1) ? $clog2(GUARD_BITS) : 1;

    tx_state_t     state;
    logic [2:0]    bit_cnt;    // bit slot within the current byte
    logic [GW-1:0] guard_cnt;
    logic [7:0]    shreg;
    logic          last_q;     // shreg holds the final payload byte
    logic          shifting;
    logic          boundary;

    assign shifting = (state == SYNC) || (state == DATA);
    assign boundary = shifting && (bit_cnt == 3'd7);

    // after sync always fetch, after a payload byte only if more follow
    assign byte_next = boundary && !((state == DATA) && last_q);

    assign line_en   = shifting || (state == GUARD);
    assign line_data = shifting && shreg[7];  // msb first, zeros in guard
    assign tx_done   = (state == DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            guard_cnt <= '0;
            last_q    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (tx_start) begin
                        state   <= SYNC;
                        bit_cnt <= '0;
                    end
                end
                SYNC, DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;  // wraps at each byte
                    if (byte_next) begin
                        state  <= DATA;
                        last_q <= tx_last;
                    end else if (boundary) begin
                        state     <= GUARD;
                        guard_cnt <= '0;
                    end
                end
                GUARD: begin
                    guard_cnt <= guard_cnt + 1'b1;
                    if (guard_cnt == GW'(GUARD_BITS - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && tx_start) begin
            shreg <= SYNC_BYTE;
        end else if (byte_next) begin
            shreg <= tx_byte;
        end else begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    // frame enable drops only once the whole guard period went out
    a_line_en_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(line_en) |-> $past((state == GUARD) && (guard_cnt == GW'(GUARD_BITS - 1))));

    // decode keeps new sends away while a frame is on the line
    a_start_in_idle: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> (state == IDLE));

endmodule

// File: common/com_pkg.sv
package com_pkg;

    // first byte of every frame, the receiver locks on it
    localparam logic [7:0] SYNC_BYTE = 8'h01;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_LOAD  = 2'd1,  // append data to the payload buffer
        OP_SEND  = 2'd2,  // start a frame from the buffer
        OP_CLEAR = 2'd3   // empty the buffer
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t    op;
        logic [7:0] data;
    } com_cmd_t;

    // transmitter, one line bit per clock in SYNC, DATA and GUARD
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        SYNC  = 3'd1,
        DATA  = 3'd2,
        GUARD = 3'd3,
        DONE  = 3'd4
    } tx_state_t;

    typedef enum logic [1:0] {
        HUNT  = 2'd0,  // collecting the sync byte
        BYTES = 2'd1,
        END   = 2'd2
    } rx_state_t;

    typedef struct packed {
        logic       sync_ok;
        logic [7:0] byte_count;
        logic       short_byte;  // frame stopped part way into a byte
    } rx_status_t;

endpackage

// File: logic/com_cmd_decode.sv
`timescale 1ns/1ps

module com_cmd_decode #(
    parameter int MAX_BYTES = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  com_pkg::com_cmd_t cmd,
    input  logic              tx_done,
    input  logic              byte_next,
    output logic              tx_start,
    output logic [7:0]        tx_byte,
    output logic              tx_last,
    output logic              busy,
    output logic              cmd_error
);
    import com_pkg::*;

    localparam int CW = $clog2(MAX_BYTES + 1);
    localparam int PW = (MAX_BYTES > 1) ? $clog2(MAX_BYTES) : 1;

    logic [7:0]    buf_mem [MAX_BYTES];
    logic [CW-1:0] fill;    // bytes held in the buffer
    logic [PW-1:0] rd_ptr;
    logic          full;
    logic          empty;
    logic          load_ok;
    logic          send_ok;
    logic          clear_ok;
    logic          reject;

    assign full  = (fill == CW'(MAX_BYTES));
    assign empty = (fill == '0);

    always_comb begin
        load_ok  = 1'b0;
        send_ok  = 1'b0;
        clear_ok = 1'b0;
        reject   = 1'b0;
        if (cmd_valid) begin
            case (cmd.op)
                OP_LOAD: begin
                    reject  = busy || full;
                    load_ok = !(busy || full);
                end
                OP_SEND: begin
                    reject  = busy || empty;
                    send_ok = !(busy || empty);
                end
                OP_CLEAR: begin
                    reject   = busy;
                    clear_ok = !busy;
                end
                default: begin
                    reject = 1'b0;  // nop is always fine
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_start  <= 1'b0;
            cmd_error <= 1'b0;
            busy      <= 1'b0;
            fill      <= '0;
            rd_ptr    <= '0;
        end else begin
            tx_start  <= send_ok;
            cmd_error <= reject;
            if (send_ok) begin
                busy <= 1'b1;
            end else if (tx_done) begin
                busy <= 1'b0;
            end
            if (clear_ok) begin
                fill <= '0;
            end else if (load_ok) begin
                fill <= fill + 1'b1;
            end
            // hold on the last byte so the pointer never leaves the buffer
            if (send_ok) begin
                rd_ptr <= '0;
            end else if (byte_next && !tx_last) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok) begin
            buf_mem[PW'(fill)] <= cmd.data;
        end
    end

    assign tx_byte = buf_mem[rd_ptr];
    assign tx_last = ((CW'(rd_ptr) + CW'(1)) == fill);

    // a full buffer never takes another byte
    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        full |=> (fill <= $past(fill)));

    // transmitter may only finish or fetch while a send is outstanding
    a_tx_inside_busy: assert property (@(posedge clk) disable iff (rst)
        (tx_done || byte_next) |-> busy);

endmodule

// File: logic/com_link.sv
`timescale 1ns/1ps

module com_link #(
    parameter int MAX_BYTES  = 16,
    parameter int GUARD_BITS = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  com_pkg::com_cmd_t   cmd,
    output logic                busy,
    output logic                cmd_error,
    output logic                line_en,
    output logic                line_data,
    output logic                rx_byte_valid,
    output logic [7:0]          rx_byte,
    output logic                frame_valid,
    output com_pkg::rx_status_t frame_status
);

    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_last;
    logic       byte_next;
    logic       tx_done;

    com_cmd_decode #(
        .MAX_BYTES (MAX_BYTES)
    ) cmd_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_done   (tx_done),
        .byte_next (byte_next),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx_last   (tx_last),
        .busy      (busy),
        .cmd_error (cmd_error)
    );

    com_txf #(
        .GUARD_BITS (GUARD_BITS)
    ) txf_inst (
        .clk       (clk),
        .rst       (rst),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx_last   (tx_last),
        .byte_next (byte_next),
        .tx_done   (tx_done),
        .line_en   (line_en),
        .line_data (line_data)
    );

    // receiver listens to the same line that leaves the chip
    com_rxf #(
        .GUARD_BITS (GUARD_BITS)
    ) rxf_inst (
        .clk           (clk),
        .rst           (rst),
        .line_en       (line_en),
        .line_data     (line_data),
        .rx_byte_valid (rx_byte_valid),
        .rx_byte       (rx_byte),
        .frame_valid   (frame_valid),
        .frame_status  (frame_status)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_com_link \
    -f com_link.f -o sim_com_link

out=$(./obj_dir/sim_com_link)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// File: tests/com_link_checker.sv
`timescale 1ns/1ps

module com_link_checker #(
    parameter int GUARD_BITS = 8
) (
    input logic                clk,
    input logic                rst,
    input logic                busy,
    input logic                cmd_error,
    input logic                line_en,
    input logic                line_data,
    input logic                rx_byte_valid,
    input logic [7:0]          rx_byte,
    input logic                frame_valid,
    input com_pkg::rx_status_t frame_status
);
    import com_pkg::*;

    localparam logic [7:0] EXP_SYNC = 8'h01;

    string      test_name;
    logic [7:0] exp_bytes[$];  // payload the host loaded
    logic [7:0] rx_bytes[$];
    bit         line_bits[$];
    logic       rst_q;
    int         exp_frames;
    int         exp_errors;
    int         frames;
    int         errors;
    int         test_errors;
    int         tests_passed = 0;
    int         tests_failed = 0;

    task automatic start_test(input string name, input int n_frames, input int n_errors);
        test_name   = name;
        exp_frames  = n_frames;
        exp_errors  = n_errors;
        frames      = 0;
        errors      = 0;
        test_errors = 0;
        exp_bytes.delete();
        rx_bytes.delete();
        line_bits.delete();
    endtask

    task automatic add_byte(input logic [7:0] b);
        exp_bytes.push_back(b);
    endtask

    task automatic clear_bytes();
        exp_bytes.delete();
    endtask

    task automatic mismatch(input string what, input int exp_val, input int act_val);
        $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp_val, act_val);
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
    endtask

    // line format: sync msb first, each payload byte msb first, guard zeros
    task automatic check_line();
        bit         exp_bits[$];
        logic [7:0] b;
        for (int i = 7; i >= 0; i--) begin
            exp_bits.push_back(EXP_SYNC[i]);
        end
        foreach (exp_bytes[k]) begin
            b = exp_bytes[k];
            for (int i = 7; i >= 0; i--) begin
                exp_bits.push_back(b[i]);
            end
        end
        repeat (GUARD_BITS) exp_bits.push_back(1'b0);
        if (line_bits.size() != exp_bits.size()) begin
            mismatch("line_en length", exp_bits.size(), line_bits.size());
        end else begin
            foreach (exp_bits[i]) begin
                if (line_bits[i] != exp_bits[i]) begin
                    mismatch($sformatf("line bit %0d", i), 32'(exp_bits[i]), 32'(line_bits[i]));
                    break;
                end
            end
        end
        line_bits.delete();
    endtask

    task automatic check_frame();
        logic [7:0] exp_rx[$];
        rx_status_t exp_status;
        frames++;
        exp_rx = exp_bytes;
        // whole guard bytes are strobed out as zeros after the payload
        repeat (GUARD_BITS / 8) exp_rx.push_back(8'h00);
        if (rx_bytes.size() != exp_rx.size()) begin
            mismatch("received byte count", exp_rx.size(), rx_bytes.size());
        end else begin
            foreach (exp_rx[k]) begin
                if (rx_bytes[k] !== exp_rx[k]) begin
                    mismatch($sformatf("rx byte %0d", k), 32'(exp_rx[k]), 32'(rx_bytes[k]));
                end
            end
        end
        exp_status.sync_ok    = 1'b1;
        exp_status.byte_count = 8'(exp_bytes.size());
        exp_status.short_byte = 1'b0;
        if (frame_status !== exp_status) begin
            mismatch("frame status", 32'(exp_status), 32'(frame_status));
        end
        rx_bytes.delete();
    endtask

    task automatic finish_test();
        if (frames != exp_frames) mismatch("frame count", exp_frames, frames);
        if (errors != exp_errors) mismatch("cmd_error count", exp_errors, errors);
        if (busy) report_problem("busy still high at the end of the test");
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
            tests_passed++;
        end else begin
            $display("FAIL %s (%0d problems)", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic report_counts();
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    endtask

    always @(posedge clk) begin
        rst_q <= rst;
        if (rst || rst_q) begin
            if (line_en || line_data || busy || cmd_error || rx_byte_valid || frame_valid) begin
                report_problem("outputs not idle during or right after reset");
            end
        end else begin
            if (cmd_error) errors++;
            if (line_en) begin
                line_bits.push_back(line_data);
                if (!busy) report_problem("line_en high while busy is low");
            end else begin
                if (line_data) report_problem("line_data high while line_en is low");
                if (line_bits.size() > 0) check_line();  // line_en just fell
            end
            if (rx_byte_valid) rx_bytes.push_back(rx_byte);
            if (frame_valid) check_frame();
        end
    end

endmodule

// File: tests/tb_com_link.sv
`timescale 1ns/1ps

module tb_com_link;
    import com_pkg::*;

    localparam int MAX_BYTES  = 16;
    localparam int GUARD_BITS = 8;
    localparam int NUM_TESTS  = 7;

    typedef struct packed {
        int n_load;       // random bytes loaded, loads past the depth get refused
        bit clear_after;  // clear the buffer before sending
        int n_send;
        bit poke_busy;    // load, send and clear while the first frame is out
        int exp_frames;
        int exp_errors;
    } test_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                cmd_valid;
    com_cmd_t            cmd;
    logic                busy;
    logic                cmd_error;
    logic                line_en;
    logic                line_data;
    logic                rx_byte_valid;
    logic [7:0]          rx_byte;
    logic                frame_valid;
    rx_status_t          frame_status;

    string names[NUM_TESTS];
    test_t tests[NUM_TESTS];
    bit    table_ready = 1'b0;
    int    seed;

    always #20 clk = ~clk;

    com_link #(
        .MAX_BYTES  (MAX_BYTES),
        .GUARD_BITS (GUARD_BITS)
    ) com_link_inst (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .busy          (busy),
        .cmd_error     (cmd_error),
        .line_en       (line_en),
        .line_data     (line_data),
        .rx_byte_valid (rx_byte_valid),
        .rx_byte       (rx_byte),
        .frame_valid   (frame_valid),
        .frame_status  (frame_status)
    );

    com_link_checker #(
        .GUARD_BITS (GUARD_BITS)
    ) checker_inst (
        .clk           (clk),
        .rst           (rst),
        .busy          (busy),
        .cmd_error     (cmd_error),
        .line_en       (line_en),
        .line_data     (line_data),
        .rx_byte_valid (rx_byte_valid),
        .rx_byte       (rx_byte),
        .frame_valid   (frame_valid),
        .frame_status  (frame_status)
    );

    task automatic set_test(input int idx, input string name, input test_t entry);
        names[idx] = name;
        tests[idx] = entry;
    endtask

    task automatic build_table();
        set_test(0, "single_byte",      '{1, 1'b0, 1, 1'b0, 1, 0});
        set_test(1, "four_bytes",       '{4, 1'b0, 1, 1'b0, 1, 0});
        set_test(2, "load_past_full",   '{MAX_BYTES + 1, 1'b0, 1, 1'b0, 1, 1});
        set_test(3, "send_empty",       '{0, 1'b0, 1, 1'b0, 0, 1});
        set_test(4, "send_after_clear", '{3, 1'b1, 1, 1'b0, 0, 1});
        set_test(5, "busy_reject",      '{5, 1'b0, 1, 1'b1, 1, 3});
        set_test(6, "resend",           '{3, 1'b0, 2, 1'b0, 2, 0});
    endtask

    task automatic send_cmd(input cmd_op_t op, input logic [7:0] data);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.data  = data;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd       = '0;
    endtask

    // every command but nop must bounce off while the frame is on the line
    task automatic poke_while_busy();
        int waited;
        waited = 0;
        while (!line_en && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!line_en) checker_inst.report_problem("line_en never rose after a send");
        send_cmd(OP_LOAD, 8'ha5);
        send_cmd(OP_SEND, 8'h00);
        send_cmd(OP_CLEAR, 8'h00);
    endtask

    task automatic wait_frame(input int n);
        int limit;
        int waited;
        limit  = 8 * (n + 1) + GUARD_BITS + 10;
        waited = 0;
        while (!frame_valid && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!frame_valid) checker_inst.report_problem("no frame status after a send");
    endtask

    task automatic run_test(input int t);
        int         fill;  // model of the buffer depth in use
        logic [7:0] b;
        test_t      e;
        e    = tests[t];
        fill = 0;
        checker_inst.start_test(names[t], e.exp_frames, e.exp_errors);
        send_cmd(OP_CLEAR, 8'h00);
        for (int i = 0; i < e.n_load; i++) begin
            b = 8'($random(seed));
            send_cmd(OP_LOAD, b);
            if (fill < MAX_BYTES) begin
                checker_inst.add_byte(b);
                fill++;
            end
        end
        if (e.clear_after) begin
            send_cmd(OP_CLEAR, 8'h00);
            checker_inst.clear_bytes();
            fill = 0;
        end
        for (int s = 0; s < e.n_send; s++) begin
            send_cmd(OP_SEND, 8'h00);
            if (fill > 0) begin
                if (e.poke_busy && s == 0) poke_while_busy();
                wait_frame(fill);
            end
        end
        repeat (4) @(negedge clk);
        checker_inst.finish_test();
    endtask

    initial begin
        seed      = 32'h28d6;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        build_table();
        table_ready = 1'b1;
        checker_inst.start_test("reset_state", 0, 0);
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        checker_inst.finish_test();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        checker_inst.report_counts();
        if (checker_inst.tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // budget is the frame lengths plus command cycles, with a margin
    initial begin : watchdog
        int limit;
        int n;
        wait (table_ready);
        limit = 200;
        for (int t = 0; t < NUM_TESTS; t++) begin
            n = (tests[t].n_load < MAX_BYTES) ? tests[t].n_load : MAX_BYTES;
            limit += tests[t].n_send * (8 * (n + 1) + GUARD_BITS + 20);
            limit += 2 * (tests[t].n_load + 8) + 50;
        end
        #(limit * 40);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule
